// File: rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Datapath width, also used for pc and addresses
`define RV_DATA_W 32

// Register file addressing
`define RV_REG_AW 5

// Architectural integer registers, x0 included
`define RV_NUM_REGS 32

// Added to the committed pc to form the
// link address of JAL and JALR
`define RV_PC_STEP 32'd4

// Value of the latched pc out of reset
// Boot address of the core
`define RV_RESET_PC 32'h8000_0000

// Notes on use
// The package pulls this file in for its struct widths
// RTL files include it where they size their own ports
// The guard keeps repeated includes harmless
// Widths are in bits, RV_PC_STEP is in bytes
// Keep RV_REG_AW and RV_NUM_REGS consistent,
// i.e. RV_NUM_REGS == 2 ** RV_REG_AW

`endif

// File: rv_pkg.sv
`include "rv_defines.svh"

package rv_pkg;

    // RV32I major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // Source of the register write-back data
    typedef enum logic [1:0] {
        WB_NONE = 2'b00,
        WB_PC4  = 2'b01,
        WB_ALU  = 2'b10,
        WB_LOAD = 2'b11
    } wb_src_e;

    // Finished instruction handed over by the memory stage
    // rd, funct3 and opcode are all taken from inst
    typedef struct packed {
        // Address of the instruction
        logic [`RV_DATA_W-1:0] pc;
        // Raw instruction word
        logic [`RV_DATA_W-1:0] inst;
        // Result computed by execute
        logic [`RV_DATA_W-1:0] alu_result;
        // Aligned word read from data memory
        logic [`RV_DATA_W-1:0] dmem_rdata;
        // Byte offset of the load address
        logic [1:0]            addr_lo;
    } mem_wb_t;

    // One register file write
    typedef struct packed {
        // Write enable, at most one cycle per commit
        logic                  we;
        // Destination register
        logic [`RV_REG_AW-1:0] addr;
        // Data to store
        logic [`RV_DATA_W-1:0] data;
    } rf_wr_t;

    // Bundle widths for quick reference
    // mem_wb_t is 4 * 32 + 2 = 130 bits
    // rf_wr_t is 1 + 5 + 32 = 38 bits
    // Field order above is msb first

endpackage

// File: load_align.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module load_align (
    input  logic [`RV_DATA_W-1:0] raw_i,
    input  logic [1:0]            addr_lo_i,
    input  logic [2:0]            funct3_i,
    output logic [`RV_DATA_W-1:0] data_o
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // Byte lane picked by the low address bits
    always_comb begin
        case (addr_lo_i)
            2'b00: byte_sel = raw_i[7:0];
            2'b01: byte_sel = raw_i[15:8];
            2'b10: byte_sel = raw_i[23:16];
            default: byte_sel = raw_i[31:24];
        endcase
    end

    // Halfword lane, bit 0 of the offset is ignored
    always_comb begin
        if (addr_lo_i[1]) begin
            half_sel = raw_i[31:16];
        end else begin
            half_sel = raw_i[15:0];
        end
    end

    // Extension by funct3
    always_comb begin
        case (funct3_i)
            // LB
            3'b000: begin
                data_o = {{(`RV_DATA_W-8){byte_sel[7]}}, byte_sel};
            end
            // LH
            3'b001: begin
                data_o = {{(`RV_DATA_W-16){half_sel[15]}}, half_sel};
            end
            // LW
            3'b010: begin
                data_o = raw_i;
            end
            // LBU
            3'b100: begin
                data_o = {{(`RV_DATA_W-8){1'b0}}, byte_sel};
            end
            // LHU
            3'b101: begin
                data_o = {{(`RV_DATA_W-16){1'b0}}, half_sel};
            end
            // Undefined encodings pass the word through
            default: begin
                data_o = raw_i;
            end
        endcase
    end

endmodule

// File: wb_unit.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module wb_unit (
    input  logic            clk,
    input  logic            rst,
    input  logic            mem_done_i,
    input  rv_pkg::mem_wb_t mem_wb_i,
    output logic            commit_o,
    output rv_pkg::rf_wr_t  rf_wr_o
);

    // Latched bundle and commit pulse
    rv_pkg::mem_wb_t       mem_wb_q;
    logic                  commit_q;

    // Decode of the latched instruction
    rv_pkg::opcode_e       opcode;
    rv_pkg::wb_src_e       wb_src;
    logic [2:0]            funct3;

    // Candidate write-back values
    logic [`RV_DATA_W-1:0] pc_plus4;
    logic [`RV_DATA_W-1:0] load_data;
    logic [`RV_DATA_W-1:0] wr_data;

    // Bundle register, loads only on the done strobe
    // A zero inst decodes to no write out of reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_wb_q.pc         <= `RV_RESET_PC;
            mem_wb_q.inst       <= '0;
            mem_wb_q.alu_result <= '0;
            mem_wb_q.dmem_rdata <= '0;
            mem_wb_q.addr_lo    <= '0;
        end else if (mem_done_i) begin
            mem_wb_q <= mem_wb_i;
        end
    end

    // One cycle pulse after each strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commit_q <= 1'b0;
        end else begin
            commit_q <= mem_done_i;
        end
    end

    // Commit doubles as the fetch pc write enable
    assign commit_o = commit_q;

    assign opcode = rv_pkg::opcode_e'(mem_wb_q.inst[6:0]);
    assign funct3 = mem_wb_q.inst[14:12];

    // Write-back source select
    always_comb begin
        case (opcode)
            rv_pkg::OPC_LUI,
            rv_pkg::OPC_AUIPC,
            rv_pkg::OPC_OP_IMM,
            rv_pkg::OPC_OP: begin
                wb_src = rv_pkg::WB_ALU;
            end
            rv_pkg::OPC_LOAD: begin
                wb_src = rv_pkg::WB_LOAD;
            end
            rv_pkg::OPC_JAL,
            rv_pkg::OPC_JALR: begin
                wb_src = rv_pkg::WB_PC4;
            end
            // Stores, branches and CSR ops commit without a write
            default: begin
                wb_src = rv_pkg::WB_NONE;
            end
        endcase
    end

    // Link address for jumps
    assign pc_plus4 = mem_wb_q.pc + `RV_PC_STEP;

    load_align load_align_i (
        .raw_i     (mem_wb_q.dmem_rdata),
        .addr_lo_i (mem_wb_q.addr_lo),
        .funct3_i  (funct3),
        .data_o    (load_data)
    );

    // Write data mux
    always_comb begin
        case (wb_src)
            rv_pkg::WB_PC4: begin
                wr_data = pc_plus4;
            end
            rv_pkg::WB_ALU: begin
                wr_data = mem_wb_q.alu_result;
            end
            rv_pkg::WB_LOAD: begin
                wr_data = load_data;
            end
            default: begin
                wr_data = '0;
            end
        endcase
    end

    // Register write, valid in the commit cycle
    always_comb begin
        rf_wr_o.we   = commit_q && (wb_src != rv_pkg::WB_NONE);
        rf_wr_o.addr = mem_wb_q.inst[11:7];
        rf_wr_o.data = wr_data;
    end

endmodule

// File: reg_file.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  rst,
    input  rv_pkg::rf_wr_t        wr_i,
    input  logic [`RV_REG_AW-1:0] rs_addr_i,
    output logic [`RV_DATA_W-1:0] rs_data_o
);

    // Integer register array
    logic [`RV_DATA_W-1:0] regs [`RV_NUM_REGS];

    // Single write port
    // x0 is never written
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.we && (wr_i.addr != '0)) begin
            regs[wr_i.addr] <= wr_i.data;
        end
    end

    // Asynchronous read port
    // Shows a write from just after its clock edge
    always_comb begin
        if (rs_addr_i == '0) begin
            rs_data_o = '0;
        end else begin
            rs_data_o = regs[rs_addr_i];
        end
    end

    // Write to x0 is still visible on wr_i.we
    // at the top level, only the array ignores it
    // No bypass from wr_i to the read port,
    // the new value appears after the edge
    // Read address is not registered
    // Array has no further ports
    // Depth is fixed by RV_NUM_REGS
    // Index width is RV_REG_AW

endmodule

// File: wb_subsys_top.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module wb_subsys_top (
    // Clock and reset
    input  logic                  clk,
    input  logic                  rst,

    // From the memory stage
    input  logic                  mem_done_i,
    input  rv_pkg::mem_wb_t       mem_wb_i,

    // Register read port
    input  logic [`RV_REG_AW-1:0] rs_addr_i,
    output logic [`RV_DATA_W-1:0] rs_data_o,

    // Commit and register write, observable outside
    output logic                  commit_o,
    output rv_pkg::rf_wr_t        rf_wr_o
);

    // Write from the write-back unit to the register file
    rv_pkg::rf_wr_t rf_wr;

    wb_unit wb_unit_i (
        .clk        (clk),
        .rst        (rst),
        .mem_done_i (mem_done_i),
        .mem_wb_i   (mem_wb_i),
        .commit_o   (commit_o),
        .rf_wr_o    (rf_wr)
    );

    reg_file reg_file_i (
        .clk       (clk),
        .rst       (rst),
        .wr_i      (rf_wr),
        .rs_addr_i (rs_addr_i),
        .rs_data_o (rs_data_o)
    );

    // Same write goes out of the top
    assign rf_wr_o = rf_wr;

    // Latency from mem_done_i to commit_o is one cycle
    // The register file takes the write at the following edge
    // commit_o also serves as the fetch pc write enable
    // No back-pressure toward the memory stage

endmodule

// File: tb_wb_subsys.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module tb_wb_subsys;

    localparam int CLK_HALF       = 10;
    localparam int DRIVE_DELAY    = 2;
    localparam int RESET_CYCLES   = 5;
    localparam int COMMIT_TIMEOUT = 10;
    localparam int RUN_LIMIT      = 3000;

    logic                  clk;
    logic                  rst;
    logic                  mem_done_i;
    rv_pkg::mem_wb_t       mem_wb_i;
    logic [`RV_REG_AW-1:0] rs_addr_i;
    logic [`RV_DATA_W-1:0] rs_data_o;
    logic                  commit_o;
    rv_pkg::rf_wr_t        rf_wr_o;

    int value_errs;
    int timeout_errs;
    int trace_errs;

    wb_subsys_top wb_subsys_top_i (
        .clk        (clk),
        .rst        (rst),
        .mem_done_i (mem_done_i),
        .mem_wb_i   (mem_wb_i),
        .rs_addr_i  (rs_addr_i),
        .rs_data_o  (rs_data_o),
        .commit_o   (commit_o),
        .rf_wr_o    (rf_wr_o)
    );

    // 20 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    task automatic check_rf_wr(input rv_pkg::rf_wr_t act, input rv_pkg::rf_wr_t exp);
        if (act.we !== exp.we) begin
            $display("Fail rf_wr_o.we: got %h, expected %h", act.we, exp.we);
            value_errs++;
        end
        if (act.addr !== exp.addr) begin
            $display("Fail rf_wr_o.addr: got %h, expected %h", act.addr, exp.addr);
            value_errs++;
        end
        // Data has no meaning without a write
        if (exp.we && (act.data !== exp.data)) begin
            $display("Fail rf_wr_o.data: got %h, expected %h", act.data, exp.data);
            value_errs++;
        end
    endtask

    task automatic check_commit(input logic act, input logic exp);
        if (act !== exp) begin
            $display("Fail commit_o: got %h, expected %h", act, exp);
            value_errs++;
        end
    endtask

    task automatic check_reg(input logic [`RV_REG_AW-1:0] addr,
                             input logic [`RV_DATA_W-1:0] act,
                             input logic [`RV_DATA_W-1:0] exp);
        if (act !== exp) begin
            $display("Fail rs_data_o (x%0d): got %h, expected %h", addr, act, exp);
            value_errs++;
        end
    endtask

    // One memory-stage handover and its commit cycle
    task automatic apply_instr(input rv_pkg::mem_wb_t bundle, input rv_pkg::rf_wr_t exp_wr);
        int             waited;
        rv_pkg::rf_wr_t idle_wr;

        @(posedge clk);
        #DRIVE_DELAY;
        // Nothing pending before the strobe
        check_commit(commit_o, 1'b0);
        mem_done_i = 1'b1;
        mem_wb_i   = bundle;
        @(posedge clk);
        #DRIVE_DELAY;
        mem_done_i = 1'b0;
        // Junk on the bus must not be latched
        mem_wb_i   = '1;
        waited = 0;
        while (!commit_o && waited < COMMIT_TIMEOUT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
        end
        if (!commit_o) begin
            $display("Commit never came for the instruction at pc %h", bundle.pc);
            timeout_errs++;
        end else begin
            if (waited != 0) begin
                $display("Commit came %0d cycles later than expected for pc %h",
                         waited, bundle.pc);
                value_errs++;
            end
            check_rf_wr(rf_wr_o, exp_wr);
            @(posedge clk);
            #DRIVE_DELAY;
            // Pulse is a single cycle
            check_commit(commit_o, 1'b0);
            // The held bundle keeps rd with the enable low
            idle_wr    = exp_wr;
            idle_wr.we = 1'b0;
            check_rf_wr(rf_wr_o, idle_wr);
        end
    endtask

    task automatic read_back_reg(input logic [`RV_REG_AW-1:0] addr,
                                 input logic [`RV_DATA_W-1:0] exp);
        @(posedge clk);
        #DRIVE_DELAY;
        rs_addr_i = addr;
        @(negedge clk);
        check_commit(commit_o, 1'b0);
        check_reg(addr, rs_data_o, exp);
    endtask

    // Guard against a stuck run
    initial begin
        repeat (RUN_LIMIT) @(posedge clk);
        $display("Run did not finish within %0d cycles", RUN_LIMIT);
        $display("Something failed");
        $finish;
    end

    initial begin
        int              fd;
        int              line_no;
        int              n;
        string           line;
        string           body;
        logic [31:0]     f_pc;
        logic [31:0]     f_inst;
        logic [31:0]     f_alu;
        logic [31:0]     f_rdata;
        logic [31:0]     f_lo;
        logic [31:0]     f_we;
        logic [31:0]     f_addr;
        logic [31:0]     f_data;
        rv_pkg::mem_wb_t bundle;
        rv_pkg::rf_wr_t  exp_wr;

        rst          = 1'b1;
        mem_done_i   = 1'b0;
        mem_wb_i     = '0;
        rs_addr_i    = '0;
        value_errs   = 0;
        timeout_errs = 0;
        trace_errs   = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        // Quiet outputs and a cleared register file after reset
        @(negedge clk);
        check_commit(commit_o, 1'b0);
        exp_wr = '0;
        check_rf_wr(rf_wr_o, exp_wr);
        for (int i = 0; i < `RV_NUM_REGS; i++) begin
            read_back_reg(i[`RV_REG_AW-1:0], '0);
        end

        fd = $fopen("wb_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file wb_trace.txt");
            trace_errs++;
        end else begin
            line_no = 0;
            while ($fgets(line, fd) != 0) begin
                line_no++;
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                body = line.substr(1, line.len() - 1);
                if (line[0] == "I") begin
                    n = $sscanf(body, "%h %h %h %h %h %h %h %h", f_pc, f_inst, f_alu,
                                f_rdata, f_lo, f_we, f_addr, f_data);
                    if (n != 8) begin
                        $display("Trace line %0d has %0d of 8 instruction fields", line_no, n);
                        trace_errs++;
                    end else begin
                        bundle.pc         = f_pc;
                        bundle.inst       = f_inst;
                        bundle.alu_result = f_alu;
                        bundle.dmem_rdata = f_rdata;
                        bundle.addr_lo    = f_lo[1:0];
                        exp_wr.we         = f_we[0];
                        exp_wr.addr       = f_addr[`RV_REG_AW-1:0];
                        exp_wr.data       = f_data;
                        apply_instr(bundle, exp_wr);
                    end
                end else if (line[0] == "R") begin
                    n = $sscanf(body, "%h %h", f_addr, f_data);
                    if (n != 2) begin
                        $display("Trace line %0d has %0d of 2 read-back fields", line_no, n);
                        trace_errs++;
                    end else begin
                        read_back_reg(f_addr[`RV_REG_AW-1:0], f_data);
                    end
                end else begin
                    $display("Trace line %0d is neither an instruction nor a read-back",
                             line_no);
                    trace_errs++;
                end
            end
            $fclose(fd);
        end

        $display("Errors: %0d value mismatches, %0d commit timeouts, %0d trace problems",
                 value_errs, timeout_errs, trace_errs);
        if (value_errs + timeout_errs + trace_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+.
rv_pkg.sv
load_align.sv
wb_unit.sv
reg_file.sv
wb_subsys_top.sv
tb_wb_subsys.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the write-back testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --timescale 1ns/1ps \
    -f build.f --top-module tb_wb_subsys \
    -Mdir obj_dir -o tb_wb_subsys \
    && ./obj_dir/tb_wb_subsys > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat "$LOG"

# Result comes from the log only
grep -q "Something failed" "$LOG" \
    && { echo "Simulation FAILED"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }

// File: wb_trace.txt
# I pc inst alu_result dmem_rdata addr_lo then expected we rd data, all hex
# R reg_addr then expected read data, all hex
I 80000000 123450b7 12345000 deadbeef 0 1 01 12345000
I 80000004 00001117 80001004 deadbeef 0 1 02 80001004
I 80000008 02a00193 0000002a deadbeef 0 1 03 0000002a
I 8000000c 00208233 92346004 deadbeef 0 1 04 92346004
I 80000010 010002ef 80000020 deadbeef 0 1 05 80000014
I 80000020 00008367 12345000 deadbeef 0 1 06 80000024
R 01 12345000
R 02 80001004
R 03 0000002a
R 04 92346004
R 05 80000014
R 06 80000024
I 80000024 00000383 00001000 f1827394 0 1 07 ffffff94
I 80000028 00000403 00001001 f1827394 1 1 08 00000073
I 8000002c 00000483 00001002 f1827394 2 1 09 ffffff82
I 80000030 00000503 00001003 f1827394 3 1 0a fffffff1
I 80000034 00001583 00001000 f1827394 0 1 0b 00007394
I 80000038 00001603 00001002 f1827394 2 1 0c fffff182
I 8000003c 00004683 00001000 f1827394 0 1 0d 00000094
I 80000040 00004703 00001001 f1827394 1 1 0e 00000073
I 80000044 00004783 00001002 f1827394 2 1 0f 00000082
I 80000048 00004803 00001003 f1827394 3 1 10 000000f1
I 8000004c 00005883 00001000 f1827394 0 1 11 00007394
I 80000050 00005903 00001002 f1827394 2 1 12 0000f182
I 80000054 00002983 00001000 f1827394 0 1 13 f1827394
R 07 ffffff94
R 08 00000073
R 0a fffffff1
R 0c fffff182
R 10 000000f1
R 12 0000f182
R 13 f1827394
I 80000058 000020a3 00001010 deadbeef 0 0 01 00000000
I 8000005c 00000163 80000000 deadbeef 0 0 02 00000000
I 80000060 000011f3 00000000 deadbeef 0 0 03 00000000
I 80000064 0000027f 55555555 deadbeef 0 0 04 00000000
R 01 12345000
R 02 80001004
R 03 0000002a
R 04 92346004
I 80000068 00100013 00000001 deadbeef 0 1 00 00000001
R 00 00000000
